/* hdl/ccip_params.svh */
`ifndef CCIP_PARAMS_SVH
`define CCIP_PARAMS_SVH

// Host port widths
`define CL_ADDR_W     32  // Cache-line address
`define CL_DATA_W     64  // One line of payload
`define MDATA_W       16  // Request tag carried through the host

// Reorder buffer sizing
`define ROB_DEPTH     16  // Outstanding reads
`define ROB_IDX_W     4   // log2 of ROB_DEPTH

// Engine-side c0 level rises when fewer free slots than this remain
`define ROB_MIN_FREE  2

// Copy engine
`define LINES_W       16  // Line count of one run

`endif

/* hdl/ccip_if_pkg.sv */
`include "ccip_params.svh"

package ccip_if_pkg;

  typedef logic [`CL_ADDR_W-1:0] t_cl_addr;  // Line address
  typedef logic [`CL_DATA_W-1:0] t_cl_data;  // Line payload
  typedef logic [`MDATA_W-1:0]   t_mdata;    // Request tag

  // Read request on c0
  typedef struct packed {
    logic     valid;
    t_mdata   mdata;
    t_cl_addr address;
  } t_c0_tx;

  // Write request on c1
  typedef struct packed {
    logic     valid;
    t_mdata   mdata;
    t_cl_addr address;
    t_cl_data data;
  } t_c1_tx;

  typedef struct packed {
    t_c0_tx c0;
    t_c1_tx c1;
  } t_if_ccip_Tx;

  // Read response, tag echoed from the request
  typedef struct packed {
    logic     valid;
    t_mdata   mdata;
    t_cl_data data;
  } t_c0_rx;

  // Write acknowledgement
  typedef struct packed {
    logic   valid;
    t_mdata mdata;
  } t_c1_rx;

  // Almost-full levels ride along with the responses
  typedef struct packed {
    t_c0_rx c0;
    t_c1_rx c1;
    logic   c0_alm_full;  // Stop new reads
    logic   c1_alm_full;  // Stop new writes
  } t_if_ccip_Rx;

  // Copy engine FSM
  typedef enum logic [1:0] {
    LB_IDLE  = 2'd0,  // Waiting for start
    LB_RUN   = 2'd1,  // Issuing reads
    LB_DRAIN = 2'd2   // All reads out, collecting acks
  } t_lb_state;

endpackage

/* hdl/ccip_reorder_buffer.sv */
`timescale 1ns/100ps
`include "ccip_params.svh"

module ccip_reorder_buffer import ccip_if_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  output t_if_ccip_Tx bb_tx,   // Toward host
  input  t_if_ccip_Rx bb_rx,   // From host
  input  t_if_ccip_Tx afu_tx,  // From copy engine
  output t_if_ccip_Rx afu_rx   // Toward copy engine
);

  localparam int unsigned IDX_W = `ROB_IDX_W;
  localparam int unsigned CNT_W = `ROB_IDX_W + 1;

  logic [IDX_W-1:0]      alloc_ptr;  // Next slot handed to a read
  logic [IDX_W-1:0]      rel_ptr;    // Oldest outstanding slot
  logic [CNT_W-1:0]      used_cnt;
  logic [CNT_W-1:0]      used_next;
  logic [CNT_W-1:0]      free_next;
  logic [`ROB_DEPTH-1:0] filled;     // Response captured, not yet released
  t_mdata                meta_mem [`ROB_DEPTH];
  t_cl_data              data_mem [`ROB_DEPTH];

  logic                  rd_accept;
  logic                  rsp_in;
  logic [IDX_W-1:0]      rsp_slot;
  logic [IDX_W-1:0]      rsp_ofs;
  logic                  head_bypass;
  logic                  head_ready;
  logic                  release_head;
  t_cl_data              head_data;

  // Host-side request registers
  logic                  rd_vld_q;
  t_mdata                rd_tag_q;
  t_cl_addr              rd_addr_q;
  logic                  wr_vld_q;
  t_mdata                wr_mdata_q;
  t_cl_addr              wr_addr_q;
  t_cl_data              wr_data_q;

  // Engine-side response registers
  logic                  rsp_vld_q;
  t_mdata                rsp_mdata_q;
  t_cl_data              rsp_data_q;
  logic                  ack_vld_q;
  t_mdata                ack_mdata_q;
  logic                  c0_af_q;

  assign rd_accept = afu_tx.c0.valid;  // Engine honors our c0 level
  assign rsp_in    = bb_rx.c0.valid;
  assign rsp_slot  = bb_rx.c0.mdata[IDX_W-1:0];  // Host echoes the slot tag
  assign rsp_ofs   = rsp_slot - rel_ptr;          // Distance from head, wraps

  // A response landing on the head slot can leave in the next cycle
  assign head_bypass  = rsp_in && (rsp_slot == rel_ptr);
  assign head_ready   = filled[rel_ptr] || head_bypass;
  assign release_head = head_ready && !bb_rx.c1_alm_full;  // Hold while writes throttled
  assign head_data    = filled[rel_ptr] ? data_mem[rel_ptr] : bb_rx.c0.data;

  always_comb begin
    used_next = used_cnt;
    if (rd_accept) begin
      used_next = used_next + 1'b1;
    end
    if (release_head) begin
      used_next = used_next - 1'b1;
    end
  end

  assign free_next = CNT_W'(`ROB_DEPTH) - used_next;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      alloc_ptr <= '0;
      rel_ptr   <= '0;
      used_cnt  <= '0;
      filled    <= '0;
      rd_vld_q  <= 1'b0;
      wr_vld_q  <= 1'b0;
      rsp_vld_q <= 1'b0;
      ack_vld_q <= 1'b0;
      c0_af_q   <= 1'b0;
    end else begin
      if (rd_accept) begin
        alloc_ptr <= alloc_ptr + 1'b1;  // Depth is a power of two
      end
      if (rsp_in) begin
        filled[rsp_slot] <= 1'b1;
      end
      if (release_head) begin
        filled[rel_ptr] <= 1'b0;  // Overrides the set above on bypass
        rel_ptr         <= rel_ptr + 1'b1;
      end
      used_cnt  <= used_next;
      rd_vld_q  <= rd_accept;
      wr_vld_q  <= afu_tx.c1.valid;
      rsp_vld_q <= release_head;
      ack_vld_q <= bb_rx.c1.valid;
      // Slot level computed on next occupancy so the engine sees it in time
      c0_af_q   <= bb_rx.c0_alm_full || (free_next < CNT_W'(`ROB_MIN_FREE));
    end
  end

  always_ff @(posedge clk) begin
    if (rd_accept) begin
      meta_mem[alloc_ptr] <= afu_tx.c0.mdata;  // Engine tag restored on release
    end
    if (rsp_in) begin
      data_mem[rsp_slot] <= bb_rx.c0.data;
    end
    rd_tag_q    <= t_mdata'(alloc_ptr);
    rd_addr_q   <= afu_tx.c0.address;
    wr_mdata_q  <= afu_tx.c1.mdata;
    wr_addr_q   <= afu_tx.c1.address;
    wr_data_q   <= afu_tx.c1.data;
    rsp_mdata_q <= meta_mem[rel_ptr];
    rsp_data_q  <= head_data;
    ack_mdata_q <= bb_rx.c1.mdata;
  end

  assign bb_tx.c0 = '{valid: rd_vld_q, mdata: rd_tag_q, address: rd_addr_q};
  assign bb_tx.c1 = '{
    valid:   wr_vld_q,
    mdata:   wr_mdata_q,
    address: wr_addr_q,
    data:    wr_data_q
  };

  assign afu_rx.c0          = '{valid: rsp_vld_q, mdata: rsp_mdata_q, data: rsp_data_q};
  assign afu_rx.c1          = '{valid: ack_vld_q, mdata: ack_mdata_q};
  assign afu_rx.c0_alm_full = c0_af_q;
  assign afu_rx.c1_alm_full = 1'b0;  // Write throttling handled here via release hold

  // Host answers only reads still outstanding, and each one once
  a_rsp_legal: assert property (@(posedge clk) disable iff (!rst_n)
    rsp_in |-> !filled[rsp_slot] && ({1'b0, rsp_ofs} < used_cnt));

  // Engine never sends a read that finds the buffer full
  a_no_overrun: assert property (@(posedge clk) disable iff (!rst_n)
    rd_accept |-> used_cnt < CNT_W'(`ROB_DEPTH));

endmodule

/* hdl/nlb_lpbk.sv */
`timescale 1ns/100ps
`include "ccip_params.svh"

module nlb_lpbk import ccip_if_pkg::*; (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  start,      // One-cycle pulse
  input  logic [`LINES_W-1:0]   num_lines,
  input  logic [`CL_ADDR_W-1:0] src_base,
  input  logic [`CL_ADDR_W-1:0] dst_base,
  output logic                  done,       // Pulses after the last ack
  output t_if_ccip_Tx           cf2ci_tx,
  input  t_if_ccip_Rx           ci2cf_rx
);

  t_lb_state           state;
  t_cl_addr            src_q;
  t_cl_addr            dst_q;
  logic [`LINES_W-1:0] lines_q;
  logic [`LINES_W-1:0] rd_cnt;   // Reads issued
  logic [`LINES_W-1:0] wr_cnt;   // Writes issued, in response order
  logic [`LINES_W-1:0] ack_cnt;
  logic [`LINES_W-1:0] ack_next;
  logic                start_ok;
  logic                rd_all;
  logic                rd_issue;
  logic                wr_issue;

  assign start_ok = (state == LB_IDLE) && start;  // Ignored mid-run
  assign rd_all   = (rd_cnt == lines_q);
  assign rd_issue = (state == LB_RUN) && !rd_all && !ci2cf_rx.c0_alm_full;
  assign wr_issue = ci2cf_rx.c0.valid;  // Responses arrive in request order
  assign ack_next = ci2cf_rx.c1.valid ? ack_cnt + 1'b1 : ack_cnt;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state   <= LB_IDLE;
      rd_cnt  <= '0;
      wr_cnt  <= '0;
      ack_cnt <= '0;
      done    <= 1'b0;
    end else begin
      done    <= 1'b0;
      ack_cnt <= ack_next;
      if (rd_issue) begin
        rd_cnt <= rd_cnt + 1'b1;
      end
      if (wr_issue) begin
        wr_cnt <= wr_cnt + 1'b1;
      end
      case (state)
        LB_IDLE: begin
          if (start_ok) begin
            rd_cnt  <= '0;
            wr_cnt  <= '0;
            ack_cnt <= '0;
            state   <= LB_RUN;
          end
        end
        LB_RUN: begin
          if (rd_all) begin
            state <= LB_DRAIN;  // Last read went out last cycle
          end
        end
        LB_DRAIN: begin
          if (ack_next == lines_q) begin
            done  <= 1'b1;
            state <= LB_IDLE;
          end
        end
        default: begin
          state <= LB_IDLE;
        end
      endcase
    end
  end

  // Run parameters, held for the whole run
  always_ff @(posedge clk) begin
    if (start_ok) begin
      src_q   <= src_base;
      dst_q   <= dst_base;
      lines_q <= num_lines;
    end
  end

  assign cf2ci_tx.c0 = '{
    valid:   rd_issue,
    mdata:   t_mdata'(rd_cnt),  // Line index as tag
    address: src_q + t_cl_addr'(rd_cnt)
  };

  // Destination offset from response count, so no address rides in mdata
  assign cf2ci_tx.c1 = '{
    valid:   wr_issue,
    mdata:   t_mdata'(wr_cnt),
    address: dst_q + t_cl_addr'(wr_cnt),
    data:    ci2cf_rx.c0.data
  };

  // Reorder buffer hands back our tags in issue order
  a_rsp_order: assert property (@(posedge clk) disable iff (!rst_n)
    ci2cf_rx.c0.valid |-> ci2cf_rx.c0.mdata == t_mdata'(wr_cnt));

endmodule

/* hdl/ccip_std_afu.sv */
`timescale 1ns/100ps
`include "ccip_params.svh"

module ccip_std_afu import ccip_if_pkg::*; (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  start,
  input  logic [`LINES_W-1:0]   num_lines,
  input  logic [`CL_ADDR_W-1:0] src_base,
  input  logic [`CL_ADDR_W-1:0] dst_base,
  output logic                  done,
  output t_if_ccip_Tx           tx,  // Host port requests
  input  t_if_ccip_Rx           rx   // Host port responses
);

  t_if_ccip_Tx afu2rob_tx;  // Engine requests, engine tags
  t_if_ccip_Rx rob2afu_rx;  // In-order responses

  ccip_reorder_buffer ccip_reorder_buffer (
    .clk    (clk),
    .rst_n  (rst_n),
    .bb_tx  (tx),
    .bb_rx  (rx),
    .afu_tx (afu2rob_tx),
    .afu_rx (rob2afu_rx)
  );

  // Loopback copy engine
  nlb_lpbk nlb_lpbk (
    .clk       (clk),
    .rst_n     (rst_n),
    .start     (start),
    .num_lines (num_lines),
    .src_base  (src_base),
    .dst_base  (dst_base),
    .done      (done),
    .cf2ci_tx  (afu2rob_tx),
    .ci2cf_rx  (rob2afu_rx)
  );

endmodule

/* tests/host_mem_model.sv */
`timescale 1ns/100ps
`include "ccip_params.svh"

module host_mem_model import ccip_if_pkg::*; #(
  parameter int MEM_LINES = 1024
) (
  input  logic        clk,
  input  logic        rst_n,
  input  logic [31:0] rnd,  // Fresh random word every rising edge
  input  t_if_ccip_Tx tx,
  output t_if_ccip_Rx rx
);

  localparam int AW = $clog2(MEM_LINES);

  t_cl_data mem [MEM_LINES];  // Loaded by the testbench before reset ends
  t_mdata   rd_tag [$];       // Reads accepted, not yet answered
  t_cl_addr rd_addr [$];
  t_mdata   ack_tag [$];
  int       ack_due [$];      // Earliest cycle for each ack
  logic     live;
  logic     af_c0;            // Current almost-full levels
  logic     af_c1;
  int       now;

  initial begin
    rx = '0;
  end

  always @(posedge clk) begin
    live <= rst_n;  // Reset seen at the edge, not at the falling edge
  end

  // Requests are sampled and responses driven mid-cycle
  always @(negedge clk) begin
    int          pick;
    t_if_ccip_Rx nxt;
    nxt = '0;
    if (!live) begin
      rd_tag.delete();
      rd_addr.delete();
      ack_tag.delete();
      ack_due.delete();
      af_c0 = 1'b0;
      af_c1 = 1'b0;
      now = 0;
    end else begin
      now = now + 1;
      if (tx.c0.valid) begin
        rd_tag.push_back(tx.c0.mdata);
        rd_addr.push_back(tx.c0.address);
      end
      if (tx.c1.valid) begin
        mem[tx.c1.address[AW-1:0]] = tx.c1.data;
        ack_tag.push_back(tx.c1.mdata);
        ack_due.push_back(now + int'(rnd[17:16]));  // 0 to 3 cycles late
      end
      // Any pending read may go next, so returns come out of order
      if (rnd[4] && rd_tag.size() > 0) begin
        pick         = int'(rnd[15:8]) % rd_tag.size();
        nxt.c0.valid = 1'b1;
        nxt.c0.mdata = rd_tag[pick];
        nxt.c0.data  = mem[rd_addr[pick][AW-1:0]];
        rd_tag.delete(pick);
        rd_addr.delete(pick);
      end
      if (ack_tag.size() > 0 && ack_due[0] <= now) begin
        nxt.c1.valid = 1'b1;
        nxt.c1.mdata = ack_tag.pop_front();
        void'(ack_due.pop_front());
      end
      // Levels flip about one cycle in sixteen, so each holds for a stretch
      if (rnd[23:20] == 4'd0) begin
        af_c0 = !af_c0;
      end
      if (rnd[27:24] == 4'd0) begin
        af_c1 = !af_c1;
      end
      nxt.c0_alm_full = af_c0;
      nxt.c1_alm_full = af_c1;
    end
    rx = nxt;
  end

endmodule

/* tests/tb_ccip_std_afu.sv */
`timescale 1ns/100ps
`include "ccip_params.svh"

module tb_ccip_std_afu import ccip_if_pkg::*; ();

  localparam int RUNS      = 8;
  localparam int MEM_LINES = 1024;
  localparam int SLACK     = 8;  // Requests the host tolerates after almost-full

  logic                  clk;
  logic                  rst_n;
  logic                  start;
  logic [`LINES_W-1:0]   num_lines;
  logic [`CL_ADDR_W-1:0] src_base;
  logic [`CL_ADDR_W-1:0] dst_base;
  logic                  done;
  t_if_ccip_Tx           tx;
  t_if_ccip_Rx           rx;
  logic [31:0]           host_rnd;

  logic [31:0] rand_state = 32'h5f05_7cfc;
  t_cl_data    ref_mem [MEM_LINES];  // Expected memory image
  int          run_lines [RUNS];
  int          run_src [RUNS];
  int          run_dst [RUNS];
  int          cur_run;
  int          cur_src;
  int          cur_dst;
  int          wr_seen;              // Writes seen in the current run
  int          rd_seen;              // Reads seen in the current run
  int          rd_total;             // Reads since reset
  logic        in_run;
  logic        done_seen;
  logic        lvl_c0;               // Host levels at the last rising edge
  logic        lvl_c1;
  int          rd_slack;
  int          wr_slack;
  int          cycles = 0;
  int          limit = 1000;
  int          errors = 0;
  int          failures = 0;

  ccip_std_afu dut (
    .clk       (clk),
    .rst_n     (rst_n),
    .start     (start),
    .num_lines (num_lines),
    .src_base  (src_base),
    .dst_base  (dst_base),
    .done      (done),
    .tx        (tx),
    .rx        (rx)
  );

  host_mem_model #(.MEM_LINES(MEM_LINES)) host (
    .clk   (clk),
    .rst_n (rst_n),
    .rnd   (host_rnd),
    .tx    (tx),
    .rx    (rx)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  function automatic logic [31:0] next_rand();
    logic [31:0] x;
    x = rand_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rand_state = x;
    return x;
  endfunction

  task automatic check(input string name, input logic [63:0] exp_val,
                       input logic [63:0] act_val);
    if (exp_val !== act_val) begin
      $display("ERR %s expected %h actual %h", name, exp_val, act_val);
      errors++;
    end
  endtask

  task automatic report_failure(input string what);
    $display("%s", what);
    failures++;
  endtask

  // Everything visible at the host port in one cycle
  task automatic observe();
    int ofs;
    rd_slack = lvl_c0 ? rd_slack + int'(tx.c0.valid) : 0;
    wr_slack = lvl_c1 ? wr_slack + int'(tx.c1.valid) : 0;
    if (rd_slack > SLACK)
      report_failure($sformatf("Run %0d kept reading under c0 almost-full", cur_run));
    if (wr_slack > SLACK)
      report_failure($sformatf("Run %0d kept writing under c1 almost-full", cur_run));
    if (tx.c0.valid) begin
      if (!in_run) begin
        report_failure("Read request seen outside a run");
      end else begin
        check($sformatf("run %0d read %0d address", cur_run, rd_seen),
              64'(cur_src + rd_seen), 64'(tx.c0.address));
        check($sformatf("run %0d read %0d tag", cur_run, rd_seen),
              64'(rd_total % `ROB_DEPTH), 64'(tx.c0.mdata));  // Slots taken as a ring
        rd_seen++;
      end
      rd_total++;
    end
    if (tx.c1.valid) begin
      if (!in_run) begin
        report_failure("Write request seen outside a run");
      end else begin
        ofs = cur_src + wr_seen;  // Writes must follow source order
        check($sformatf("run %0d write %0d address", cur_run, wr_seen),
              64'(cur_dst + wr_seen), 64'(tx.c1.address));
        check($sformatf("run %0d write %0d data", cur_run, wr_seen),
              ref_mem[ofs], tx.c1.data);
        wr_seen++;
      end
    end
    if (done) begin
      if (!in_run || done_seen)
        report_failure("Done pulsed with no run in progress");
      done_seen = 1'b1;
    end
  endtask

  task automatic tick();
    @(posedge clk);
    lvl_c0   = rx.c0_alm_full;
    lvl_c1   = rx.c1_alm_full;
    host_rnd = next_rand();
    cycles++;
    @(negedge clk);
    observe();
  endtask

  initial begin
    wait (cycles > limit);
    $display("Timeout after %0d cycles, run %0d never signalled done", limit, cur_run);
    $display("Errors: %0d value mismatches, %0d other failures", errors, failures + 1);
    $display("TEST FAILED");
    $finish;
  end

  initial begin
    int total;
    int lo;
    int hi;
    rst_n     = 1'b0;
    start     = 1'b0;
    num_lines = '0;
    src_base  = '0;
    dst_base  = '0;
    host_rnd  = '0;
    in_run    = 1'b0;
    done_seen = 1'b0;
    lvl_c0    = 1'b0;
    lvl_c1    = 1'b0;
    rd_slack  = 0;
    wr_slack  = 0;
    cur_run   = 0;
    wr_seen   = 0;
    rd_seen   = 0;
    rd_total  = 0;
    for (int i = 0; i < MEM_LINES; i++) begin
      ref_mem[i]  = {next_rand(), 32'(i)};  // Address in the low half
      host.mem[i] = ref_mem[i];
    end
    total = 0;
    for (int r = 0; r < RUNS; r++) begin
      run_lines[r] = 1 + int'(next_rand() % 32'd40);
      lo           = int'(next_rand() % 32'd472);
      hi           = 512 + int'(next_rand() % 32'd472);  // Halves never overlap
      if ((next_rand() & 32'd1) != 32'd0) begin
        run_src[r] = hi;
        run_dst[r] = lo;
      end else begin
        run_src[r] = lo;
        run_dst[r] = hi;
      end
      total += run_lines[r];
    end
    limit = 200 * total + 1000;

    repeat (3) tick();
    rst_n = 1'b1;
    repeat (4) begin
      tick();
      check("reset c0 valid", 64'(1'b0), 64'(tx.c0.valid));
      check("reset c1 valid", 64'(1'b0), 64'(tx.c1.valid));
      check("reset done", 64'(1'b0), 64'(done));
    end

    for (int r = 0; r < RUNS; r++) begin
      cur_run   = r;
      cur_src   = run_src[r];
      cur_dst   = run_dst[r];
      wr_seen   = 0;
      rd_seen   = 0;
      done_seen = 1'b0;
      in_run    = 1'b1;
      start     = 1'b1;
      num_lines = run_lines[r][`LINES_W-1:0];
      src_base  = cur_src;
      dst_base  = cur_dst;
      tick();
      start = 1'b0;
      tick();
      // Swapped bases, so an accepted second start would corrupt the source
      start     = 1'b1;
      num_lines = 16'd5;
      src_base  = cur_dst;
      dst_base  = cur_src;
      tick();
      start = 1'b0;
      while (!done_seen) begin
        tick();
      end
      in_run = 1'b0;
      check($sformatf("run %0d read count", r), 64'(run_lines[r]), 64'(rd_seen));
      check($sformatf("run %0d write count", r), 64'(run_lines[r]), 64'(wr_seen));
      for (int i = 0; i < run_lines[r]; i++) begin
        ref_mem[cur_dst + i] = ref_mem[cur_src + i];
      end
      for (int a = 0; a < MEM_LINES; a++) begin
        check($sformatf("run %0d memory line %0d", r, a), ref_mem[a], host.mem[a]);
      end
      repeat (3) tick();  // Quiet gap between runs
    end

    $display("Errors: %0d value mismatches, %0d other failures", errors, failures);
    if (errors == 0 && failures == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

/* tb.f */
+incdir+hdl
hdl/ccip_if_pkg.sv
hdl/ccip_reorder_buffer.sv
hdl/nlb_lpbk.sv
hdl/ccip_std_afu.sv
tests/host_mem_model.sv
tests/tb_ccip_std_afu.sv

/* run_sim.sh */
#!/bin/sh
# Compile and run the AFU testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
  --top-module tb_ccip_std_afu -Mdir obj_dir -o tb_sim -f tb.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/tb_sim)
sim_status=$?
printf '%s\n' "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if printf '%s\n' "$sim_out" | grep -qx 'TEST OK'; then
  exit 0
fi
echo "Simulation did not pass"
exit 1
